// File: files.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/tag_data_sram.sv
verilog/line_state_table.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the data-cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module dcache_tb \
  -f files.f \
  -o dcache_sim

# Raise the error limit so the testbench reports the failure itself
./obj_dir/dcache_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: verification/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tb;

  import dcache_pkg::*;

  localparam int N_DIRECTED = 40;
  localparam int N_RANDOM   = 300;
  localparam int RST_CYCLES = 16;
  localparam int LIMIT      = 40 * (N_DIRECTED + N_RANDOM) + RST_CYCLES;

  logic         clk_i = 1'b0;
  logic         rst_i;
  logic         core_sel_i;
  dc_core_req_t core_req_i;
  logic [31:0]  core_rdata_o;
  logic         core_stall_o;
  logic         mem_valid_o;
  dc_mem_req_t  mem_req_o;
  logic         mem_ready_i = 1'b0;
  logic [31:0]  mem_rdata_i = 32'b0;

  logic [31:0] mem_words [logic [31:0]];
  int unsigned wait_cnt = 0;
  int          cycle_cnt = 0;
  logic [3:0]  masks [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};

  always #20 clk_i = ~clk_i;

  dcache_top i_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_sel_i   (core_sel_i),
    .core_req_i   (core_req_i),
    .core_rdata_o (core_rdata_o),
    .core_stall_o (core_stall_o),
    .mem_valid_o  (mem_valid_o),
    .mem_req_o    (mem_req_o),
    .mem_ready_i  (mem_ready_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem_words.exists(addr)) begin
      return mem_words[addr];
    end
    return addr ^ 32'hA5A5_5A5A;
  endfunction

  function automatic logic [31:0] line_addr(input logic [7:0] tag, input logic [8:0] index);
    return {`DC_WINDOW_BASE, tag, index, 2'b00};
  endfunction

  // Main memory with 0 to 3 wait cycles per transfer
  always @(posedge clk_i) begin
    if (rst_i) begin
      mem_ready_i <= 1'b0;
      wait_cnt    <= 0;
    end else if (mem_ready_i) begin
      mem_ready_i <= 1'b0;
      if (mem_req_o.we) begin
        mem_words[mem_req_o.addr] = mem_req_o.wdata;
      end
      wait_cnt <= $urandom_range(3, 0);
    end else if (mem_valid_o) begin
      if (wait_cnt == 0) begin
        mem_ready_i <= 1'b1;
        mem_rdata_i <= read_word(mem_req_o.addr);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > LIMIT) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  always @(posedge clk_i) begin
    if (i_dut.i_chk.fail_flag) begin
      abort_run("A checker assertion failed");
    end
  end

  // One request; returns cycles after acceptance and memory transfers seen
  task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] mask, input logic we,
                       output int lat, output int xfers);
    dc_core_req_t req;
    int           n;
    req.addr.raw = addr;
    req.wdata    = wdata;
    req.mask     = mask;
    req.we       = we;
    @(posedge clk_i);
    core_sel_i <= 1'b1;
    core_req_i <= req;
    n     = 0;
    xfers = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (mem_valid_o && mem_ready_i) begin
        xfers++;
      end
    end while (core_stall_o);
    lat = n - 1;
  endtask

  task automatic load(input logic [31:0] addr);
    int lat;
    int xfers;
    issue(addr, 32'b0, 4'b1111, 1'b0, lat, xfers);
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] mask);
    int lat;
    int xfers;
    issue(addr, wdata, mask, 1'b1, lat, xfers);
  endtask

  initial begin
    int lat;
    int xfers;
    logic [7:0] tag;
    logic [8:0] index;
    void'($urandom(90));
    rst_i      = 1'b1;
    core_sel_i = 1'b0;
    core_req_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    // Cold miss, then a hit to the same word
    issue(line_addr(8'h01, 9'd5), 32'b0, 4'b1111, 1'b0, lat, xfers);
    assert (xfers == 1) else begin
      $display("** Error xfers=0x%h expected 0x1 on cold miss", xfers);
      abort_run("Cold miss did not issue exactly one memory read");
    end
    issue(line_addr(8'h01, 9'd5), 32'b0, 4'b1111, 1'b0, lat, xfers);
    assert (lat == 3 && xfers == 0) else begin
      $display("** Error latency=0x%h xfers=0x%h expected 0x3 0x0", lat, xfers);
      abort_run("Load hit took the wrong number of cycles");
    end

    // Full stores to a clean line and to a dirty hit
    store(line_addr(8'h01, 9'd5), 32'h1234_5678, 4'b1111);
    load(line_addr(8'h01, 9'd5));
    store(line_addr(8'h01, 9'd5), 32'hCAFE_F00D, 4'b1111);
    load(line_addr(8'h01, 9'd5));

    // Partial stores to missing lines
    for (int m = 0; m < 7; m++) begin
      store(line_addr(8'h02, 9'd20 + 9'(m)), 32'h0000_BE00 + 32'(m), masks[m]);
      load(line_addr(8'h02, 9'd20 + 9'(m)));
    end

    // Partial stores hitting a dirty line
    for (int m = 0; m < 7; m++) begin
      store(line_addr(8'h02, 9'd20), 32'h7700_6600 + 32'(m * 17), masks[m]);
      load(line_addr(8'h02, 9'd20));
    end

    // Conflicts on dirty lines force write-back
    load(line_addr(8'h03, 9'd5));
    store(line_addr(8'h04, 9'd20), 32'hDEAD_BEEF, 4'b1111);
    store(line_addr(8'h05, 9'd21), 32'h0000_00A1, 4'b0010);
    load(line_addr(8'h01, 9'd5));
    load(line_addr(8'h04, 9'd20));
    load(line_addr(8'h02, 9'd21));

    // Random traffic over four tags and eight indices
    for (int r = 0; r < N_RANDOM; r++) begin
      tag   = 8'h10 + 8'($urandom_range(3, 0));
      index = 9'd100 + 9'($urandom_range(7, 0));
      if ($urandom_range(1, 0) == 0) begin
        load(line_addr(tag, index));
      end else begin
        store(line_addr(tag, index), $urandom, masks[$urandom_range(6, 0)]);
      end
    end

    @(posedge clk_i);
    core_sel_i <= 1'b0;
    repeat (4) @(posedge clk_i);

    if (i_dut.i_chk.fail_flag) begin
      abort_run("A checker assertion failed at the end of the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: verification/dcache_assertions.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_assertions (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic                     core_sel_i,
  input dcache_pkg::dc_core_req_t core_req_i,
  input logic [31:0]              core_rdata_o,
  input logic                     core_stall_o,
  input logic                     mem_valid_o,
  input dcache_pkg::dc_mem_req_t  mem_req_o,
  input logic                     mem_ready_i
);

  import dcache_pkg::*;

  localparam int KEY_W = `DC_TAG_W + `DC_INDEX_W;

  // Shadow of core-visible memory, keyed by tag and index
  logic [31:0]       shadow_q [2**KEY_W];
  logic [2**KEY_W-1:0] written_q;
  logic              busy_q;
  logic              done;
  logic [KEY_W-1:0]  core_key;
  logic [KEY_W-1:0]  mem_key;
  dc_addr_u          mem_addr;
  logic [31:0]       ld_expect;
  logic [31:0]       wb_expect;
  logic              fail_flag = 1'b0;

  function automatic logic [31:0] init_word(input logic [KEY_W-1:0] key);
    return {`DC_WINDOW_BASE, key, 2'b00} ^ 32'hA5A5_5A5A;
  endfunction

  // Enabled lanes take consecutive low bytes of the store data
  function automatic logic [31:0] apply_store(input logic [31:0] old,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  mask);
    logic [31:0] res;
    int          lane;
    res  = old;
    lane = 0;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = wdata[8*lane +: 8];
        lane++;
      end
    end
    return res;
  endfunction

  assign done          = busy_q && !core_stall_o;
  assign core_key      = {core_req_i.addr.f.tag, core_req_i.addr.f.index};
  assign mem_addr.raw  = mem_req_o.addr;
  assign mem_key       = {mem_addr.f.tag, mem_addr.f.index};
  assign ld_expect     = written_q[core_key] ? shadow_q[core_key] : init_word(core_key);
  assign wb_expect     = written_q[mem_key] ? shadow_q[mem_key] : init_word(mem_key);

  always @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      written_q <= '0;
    end else if (!busy_q && core_sel_i) begin
      busy_q <= 1'b1;
    end else if (done) begin
      busy_q <= 1'b0;
      if (core_req_i.we) begin
        shadow_q[core_key]  <= apply_store(ld_expect, core_req_i.wdata, core_req_i.mask);
        written_q[core_key] <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !mem_valid_o && !core_stall_o)
  else begin
    fail_flag = 1'b1;
    $error("Memory valid or core stall is high right after reset");
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o))
  else begin
    fail_flag = 1'b1;
    $error("Memory request dropped or changed while waiting for ready");
  end

  a_load_data: assert property (@(posedge clk_i) disable iff (rst_i)
    done && !core_req_i.we |-> core_rdata_o == ld_expect)
  else begin
    fail_flag = 1'b1;
    $error("** Error core_rdata_o=0x%h expected 0x%h addr 0x%h",
           core_rdata_o, ld_expect, core_req_i.addr.raw);
  end

  a_writeback: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && mem_req_o.we |->
      mem_addr.f.upper == `DC_WINDOW_BASE && mem_req_o.wdata == wb_expect)
  else begin
    fail_flag = 1'b1;
    $error("** Error mem_req_o.wdata=0x%h expected 0x%h addr 0x%h",
           mem_req_o.wdata, wb_expect, mem_req_o.addr);
  end

  // Core requests are word aligned, so a refill reads the request address
  a_refill_addr: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_req_o.we |->
      mem_req_o.addr == core_req_i.addr.raw)
  else begin
    fail_flag = 1'b1;
    $error("** Error mem_req_o.addr=0x%h expected 0x%h",
           mem_req_o.addr, core_req_i.addr.raw);
  end

endmodule

bind dcache_top dcache_assertions i_chk (.*);

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Core side
  input  logic                     core_sel_i,
  input  dcache_pkg::dc_core_req_t core_req_i,
  output logic [31:0]              core_rdata_o,
  output logic                     core_stall_o,
  // Main memory
  output logic                     mem_valid_o,
  output dcache_pkg::dc_mem_req_t  mem_req_o,
  input  logic                     mem_ready_i,
  input  logic [31:0]              mem_rdata_i
);

  import dcache_pkg::*;

  logic                   wr_en;
  logic [`DC_INDEX_W-1:0] wr_index;
  logic [3:0]             wr_mask;
  dc_line_t               wr_line;
  logic                   rd_en;
  logic [`DC_INDEX_W-1:0] rd_index;
  dc_line_t               rd_line;

  logic st_valid;
  logic st_dirty;
  logic st_upd;
  logic st_upd_valid;
  logic st_upd_dirty;

  dcache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .core_sel_i     (core_sel_i),
    .core_req_i     (core_req_i),
    .core_rdata_o   (core_rdata_o),
    .core_stall_o   (core_stall_o),
    .wr_en_o        (wr_en),
    .wr_index_o     (wr_index),
    .wr_mask_o      (wr_mask),
    .wr_line_o      (wr_line),
    .rd_en_o        (rd_en),
    .rd_index_o     (rd_index),
    .rd_line_i      (rd_line),
    .st_valid_i     (st_valid),
    .st_dirty_i     (st_dirty),
    .st_upd_o       (st_upd),
    .st_upd_valid_o (st_upd_valid),
    .st_upd_dirty_o (st_upd_dirty),
    .mem_valid_o    (mem_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_ready_i    (mem_ready_i),
    .mem_rdata_i    (mem_rdata_i)
  );

  tag_data_sram i_sram (
    .clk_i      (clk_i),
    .wr_en_i    (wr_en),
    .wr_index_i (wr_index),
    .wr_mask_i  (wr_mask),
    .wr_line_i  (wr_line),
    .rd_en_i    (rd_en),
    .rd_index_i (rd_index),
    .rd_line_o  (rd_line)
  );

  // Table is indexed by the request held on the core port
  line_state_table i_state (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .index_i     (core_req_i.addr.f.index),
    .valid_o     (st_valid),
    .dirty_o     (st_dirty),
    .upd_i       (st_upd),
    .upd_valid_i (st_upd_valid),
    .upd_dirty_i (st_upd_dirty)
  );

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Core side
  input  logic                       core_sel_i,
  input  dcache_pkg::dc_core_req_t   core_req_i,
  output logic [31:0]                core_rdata_o,
  output logic                       core_stall_o,
  // Tag and data RAM
  output logic                       wr_en_o,
  output logic [`DC_INDEX_W-1:0]     wr_index_o,
  output logic [3:0]                 wr_mask_o,
  output dcache_pkg::dc_line_t       wr_line_o,
  output logic                       rd_en_o,
  output logic [`DC_INDEX_W-1:0]     rd_index_o,
  input  dcache_pkg::dc_line_t       rd_line_i,
  // Valid and dirty table
  input  logic                       st_valid_i,
  input  logic                       st_dirty_i,
  output logic                       st_upd_o,
  output logic                       st_upd_valid_o,
  output logic                       st_upd_dirty_o,
  // Main memory
  output logic                       mem_valid_o,
  output dcache_pkg::dc_mem_req_t    mem_req_o,
  input  logic                       mem_ready_i,
  input  logic [31:0]                mem_rdata_i
);

  import dcache_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_COMPARE,
    ST_CACHE_WRITE,
    ST_MEM_READ,
    ST_MEM_WRITE,
    ST_DONE
  } state_e;

  state_e      state_q, state_d;
  logic [31:0] wbuf_q, wbuf_d;
  dc_mem_req_t mem_req_q, mem_req_d;

  logic        full_store;
  logic        tag_hit;
  dc_addr_u    wb_addr;
  dc_mem_req_t rd_req;

  // Place the low bytes of wdata on the lanes named by mask, then merge
  function automatic logic [31:0] merge_word(input logic [31:0] base,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  mask);
    logic [31:0] placed;
    logic [31:0] lanes;
    case (mask)
      4'b0010: placed = {16'b0, wdata[7:0], 8'b0};
      4'b0100: placed = {8'b0, wdata[7:0], 16'b0};
      4'b1000: placed = {wdata[7:0], 24'b0};
      4'b1100: placed = {wdata[15:0], 16'b0};
      default: placed = wdata;
    endcase
    lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (base & ~lanes) | (placed & lanes);
  endfunction

  assign full_store = core_req_i.we && (core_req_i.mask == 4'b1111);
  assign tag_hit    = st_valid_i && (rd_line_i.tag == core_req_i.addr.f.tag);

  // Victim address from window base, stored tag and index
  always_comb begin
    wb_addr.f.upper  = `DC_WINDOW_BASE;
    wb_addr.f.tag    = rd_line_i.tag;
    wb_addr.f.index  = core_req_i.addr.f.index;
    wb_addr.f.offset = 2'b00;
  end

  always_comb begin
    rd_req.addr  = {core_req_i.addr.raw[31:2], 2'b00};
    rd_req.wdata = 32'b0;
    rd_req.we    = 1'b0;
  end

  always_comb begin
    state_d   = state_q;
    wbuf_d    = wbuf_q;
    mem_req_d = mem_req_q;
    case (state_q)
      ST_IDLE: begin
        if (core_sel_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        // Stores to clean or invalid lines skip the tag compare
        if (core_req_i.we && !(st_valid_i && st_dirty_i)) begin
          if (full_store) begin
            wbuf_d  = core_req_i.wdata;
            state_d = ST_CACHE_WRITE;
          end else begin
            mem_req_d = rd_req;
            state_d   = ST_MEM_READ;
          end
        end else begin
          state_d = ST_COMPARE;
        end
      end
      ST_COMPARE: begin
        if (tag_hit) begin
          if (core_req_i.we) begin
            wbuf_d  = merge_word(rd_line_i.data, core_req_i.wdata, core_req_i.mask);
            state_d = ST_CACHE_WRITE;
          end else begin
            wbuf_d  = rd_line_i.data;
            state_d = ST_DONE;
          end
        end else if (st_valid_i && st_dirty_i) begin
          mem_req_d.addr  = wb_addr.raw;
          mem_req_d.wdata = rd_line_i.data;
          mem_req_d.we    = 1'b1;
          wbuf_d          = core_req_i.wdata;
          state_d         = ST_MEM_WRITE;
        end else begin
          mem_req_d = rd_req;
          state_d   = ST_MEM_READ;
        end
      end
      ST_MEM_WRITE: begin
        if (mem_ready_i) begin
          if (full_store) begin
            state_d = ST_CACHE_WRITE;
          end else begin
            mem_req_d = rd_req;
            state_d   = ST_MEM_READ;
          end
        end
      end
      ST_MEM_READ: begin
        if (mem_ready_i) begin
          if (core_req_i.we) begin
            wbuf_d = merge_word(mem_rdata_i, core_req_i.wdata, core_req_i.mask);
          end else begin
            wbuf_d = mem_rdata_i;
          end
          state_d = ST_CACHE_WRITE;
        end
      end
      ST_CACHE_WRITE: begin
        state_d = ST_DONE;
      end
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wbuf_q    <= wbuf_d;
    mem_req_q <= mem_req_d;
  end

  // Core handshake
  assign core_stall_o = (state_q == ST_IDLE) ? core_sel_i : (state_q != ST_DONE);
  assign core_rdata_o = wbuf_q;

  // RAM ports, only a store onto its own cached line writes by byte lanes
  assign rd_en_o        = (state_q == ST_LOOKUP);
  assign rd_index_o     = core_req_i.addr.f.index;
  assign wr_en_o        = (state_q == ST_CACHE_WRITE);
  assign wr_index_o     = core_req_i.addr.f.index;
  assign wr_mask_o      = (core_req_i.we && tag_hit) ? core_req_i.mask : 4'b1111;
  assign wr_line_o.tag  = core_req_i.addr.f.tag;
  assign wr_line_o.data = wbuf_q;

  // Line state, stores leave the line dirty
  assign st_upd_o       = (state_q == ST_CACHE_WRITE);
  assign st_upd_valid_o = 1'b1;
  assign st_upd_dirty_o = core_req_i.we;

  // Memory request held until ready
  assign mem_valid_o = (state_q == ST_MEM_READ) || (state_q == ST_MEM_WRITE);
  assign mem_req_o   = mem_req_q;

endmodule

// File: verilog/line_state_table.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module line_state_table (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`DC_INDEX_W-1:0] index_i,
  output logic                   valid_o,
  output logic                   dirty_o,
  input  logic                   upd_i,
  input  logic                   upd_valid_i,
  input  logic                   upd_dirty_i
);

  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (upd_i) begin
      valid_q[index_i] <= upd_valid_i;
      dirty_q[index_i] <= upd_dirty_i;
    end
  end

  // Lookup is combinational
  assign valid_o = valid_q[index_i];
  assign dirty_o = dirty_q[index_i];

endmodule

// File: verilog/tag_data_sram.sv
`timescale 1ns/1ns
`include "dcache_settings.svh"

module tag_data_sram (
  input  logic                   clk_i,
  input  logic                   wr_en_i,
  input  logic [`DC_INDEX_W-1:0] wr_index_i,
  input  logic [3:0]             wr_mask_i,
  input  dcache_pkg::dc_line_t   wr_line_i,
  input  logic                   rd_en_i,
  input  logic [`DC_INDEX_W-1:0] rd_index_i,
  output dcache_pkg::dc_line_t   rd_line_o
);

  import dcache_pkg::*;

  dc_line_t mem_q [`DC_LINES];
  dc_line_t rd_line_q;

  // Tag is always written, data only on enabled byte lanes
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_index_i].tag <= wr_line_i.tag;
      for (int b = 0; b < 4; b++) begin
        if (wr_mask_i[b]) begin
          mem_q[wr_index_i].data[8*b +: 8] <= wr_line_i.data[8*b +: 8];
        end
      end
    end
  end

  // Read of a line under write sees the old entry
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_line_q <= mem_q[rd_index_i];
    end
  end

  assign rd_line_o = rd_line_q;

endmodule

// File: verilog/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

  // Core address split into window, tag, index and byte offset
  typedef struct packed {
    logic [31-`DC_TAG_W-`DC_INDEX_W-2:0] upper;
    logic [`DC_TAG_W-1:0]                tag;
    logic [`DC_INDEX_W-1:0]              index;
    logic [1:0]                          offset;
  } dc_addr_fields_t;

  typedef union packed {
    logic [31:0]     raw;
    dc_addr_fields_t f;
  } dc_addr_u;

  // Load or store from the core
  typedef struct packed {
    dc_addr_u    addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic        we;
  } dc_core_req_t;

  // One RAM entry
  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic [31:0]          data;
  } dc_line_t;

  // Word request toward main memory
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } dc_mem_req_t;

endpackage

// File: verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Cache geometry, direct mapped with one word per line
`define DC_LINES 512
`define DC_INDEX_W 9
`define DC_TAG_W 8

// Address bits 31:19 of the cacheable window (base 0x4000_0000)
`define DC_WINDOW_BASE 13'h0800

`endif
